//--- verilog/kbd_cfg.svh
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// Scan-code FIFO address width, depth is 2**AW
`define KBD_FIFO_AW 3

// Host register address width, four registers
`define KBD_REG_AW 2

// Frame-error counter width, saturates at all ones
`define KBD_ERRCNT_W 8

`endif

//--- verilog/kbd_pkg.sv
`include "kbd_cfg.svh"

package kbd_pkg;

    typedef logic [7:0] scan_code_t;                  // One PS/2 scan-code byte
    typedef logic [7:0] ascii_t;                      // ASCII character
    typedef logic [`KBD_FIFO_AW-1:0] fifo_ptr_t;      // FIFO read/write pointer
    typedef logic [`KBD_REG_AW-1:0] reg_addr_t;       // Host register address
    typedef logic [7:0] reg_data_t;                   // Host register data

    // Receiver FSM
    typedef enum logic [1:0] {
        idle,
        data,
        check
    } rx_state_t;

    // Decoder prefix FSM
    typedef enum logic [1:0] {
        normal,
        after_f0,
        after_e0
    } dec_state_t;

endpackage

//--- verilog/ps2_frame_rx.sv
module ps2_frame_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                rx_enable,
    output logic                code_valid,
    output kbd_pkg::scan_code_t code,
    output logic                frame_error
);
    import kbd_pkg::*;

    logic [1:0]  clk_sync;      // Bit 1 is the settled copy
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall;
    logic [10:0] frame;         // Start in bit 0, stop in bit 10 once full
    logic [3:0]  bit_cnt;
    logic        frame_ok;
    rx_state_t   state;

    // Both lines idle high, so reset the synchronizers high to avoid a false edge
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];   // Keyboard drives data, we sample on fall

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];

    always_ff @(posedge clk) begin
        if (reset || !rx_enable) begin
            state       <= idle;
            bit_cnt     <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                idle: begin
                    if (fall) begin                 // Start bit
                        bit_cnt <= 4'd1;
                        state   <= data;
                    end
                end
                data: begin
                    if (fall) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd10) begin // Eleventh bit is the stop bit
                            state <= check;
                        end
                    end
                end
                check: begin
                    code_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                    state       <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // LSB first on the wire, so shift in from the top
    always_ff @(posedge clk) begin
        if (fall && state != check) begin
            frame <= {data_sync[1], frame[10:1]};
        end
        if (state == check) begin
            code <= frame[8:1];
        end
    end

endmodule

//--- verilog/scan_fifo.sv
`include "kbd_cfg.svh"

module scan_fifo (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  kbd_pkg::scan_code_t push_data,
    input  logic                pop,
    input  logic                overflow_clear,
    output kbd_pkg::scan_code_t fifo_data,
    output logic                fifo_not_empty,
    output logic                overflow
);
    import kbd_pkg::*;

    localparam int DEPTH = 1 << `KBD_FIFO_AW;

    scan_code_t mem [DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    logic       full;           // Tells full from empty when pointers match
    logic       push_ok;
    logic       pop_ok;

    assign fifo_not_empty = full || (wr_ptr != rd_ptr);
    assign push_ok        = push && !full;
    assign pop_ok         = pop && fifo_not_empty;
    assign fifo_data      = mem[rd_ptr];   // Head entry, always visible

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            full     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok && ((wr_ptr + 1'b1) == rd_ptr)) begin
                full <= 1'b1;
            end else if (pop_ok && !push_ok) begin
                full <= 1'b0;
            end
            if (overflow_clear) begin
                overflow <= 1'b0;
            end
            if (push && full) begin     // Byte dropped, flag stays until cleared
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/scan_to_ascii.sv
module scan_to_ascii (
    input  logic                clk,
    input  logic                reset,
    input  logic                decode_enable,
    input  logic                fifo_not_empty,
    input  kbd_pkg::scan_code_t fifo_data,
    output logic                pop,
    output logic                key_valid,
    output kbd_pkg::ascii_t     key_ascii,
    output logic                key_release,
    output logic                shift_held
);
    import kbd_pkg::*;

    dec_state_t state;
    scan_code_t byte_q;
    logic       byte_vld;
    logic       shift_l;
    logic       shift_r;
    ascii_t     map_ascii;
    logic       map_hit;
    logic       is_release;

    assign shift_held = shift_l | shift_r;
    assign is_release = (state == after_f0);
    assign map_hit    = (map_ascii != 8'h00);

    // Pop is a one-cycle strobe, the FIFO head moves before the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            pop      <= 1'b0;
            byte_vld <= 1'b0;
        end else begin
            pop      <= decode_enable && fifo_not_empty && !pop;
            byte_vld <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            byte_q <= fifo_data;
        end
    end

    // Set 2 make codes, lower case letters and digits
    always_comb begin
        map_ascii = 8'h00;
        case (byte_q)
            8'h1C: map_ascii = 8'h61;   // a
            8'h32: map_ascii = 8'h62;
            8'h21: map_ascii = 8'h63;
            8'h23: map_ascii = 8'h64;
            8'h24: map_ascii = 8'h65;
            8'h2B: map_ascii = 8'h66;
            8'h34: map_ascii = 8'h67;
            8'h33: map_ascii = 8'h68;
            8'h43: map_ascii = 8'h69;
            8'h3B: map_ascii = 8'h6A;
            8'h42: map_ascii = 8'h6B;
            8'h4B: map_ascii = 8'h6C;
            8'h3A: map_ascii = 8'h6D;
            8'h31: map_ascii = 8'h6E;
            8'h44: map_ascii = 8'h6F;
            8'h4D: map_ascii = 8'h70;
            8'h15: map_ascii = 8'h71;
            8'h2D: map_ascii = 8'h72;
            8'h1B: map_ascii = 8'h73;
            8'h2C: map_ascii = 8'h74;
            8'h3C: map_ascii = 8'h75;
            8'h2A: map_ascii = 8'h76;
            8'h1D: map_ascii = 8'h77;
            8'h22: map_ascii = 8'h78;
            8'h35: map_ascii = 8'h79;
            8'h1A: map_ascii = 8'h7A;   // z
            8'h45: map_ascii = 8'h30;   // 0
            8'h16: map_ascii = 8'h31;
            8'h1E: map_ascii = 8'h32;
            8'h26: map_ascii = 8'h33;
            8'h25: map_ascii = 8'h34;
            8'h2E: map_ascii = 8'h35;
            8'h36: map_ascii = 8'h36;
            8'h3D: map_ascii = 8'h37;
            8'h3E: map_ascii = 8'h38;
            8'h46: map_ascii = 8'h39;   // 9
            default: map_ascii = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= normal;
            shift_l     <= 1'b0;
            shift_r     <= 1'b0;
            key_valid   <= 1'b0;
            key_ascii   <= '0;
            key_release <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (byte_vld) begin
                case (state)
                    after_e0: begin
                        // Extended break is E0 F0 xx, skip through to the code
                        if (byte_q != 8'hF0) begin
                            state <= normal;
                        end
                    end
                    default: begin
                        if (byte_q == 8'hF0) begin
                            state <= after_f0;
                        end else if (byte_q == 8'hE0) begin
                            state <= after_e0;
                        end else begin
                            state <= normal;
                            if (byte_q == 8'h12) begin          // Left shift
                                shift_l <= !is_release;
                            end else if (byte_q == 8'h59) begin // Right shift
                                shift_r <= !is_release;
                            end else if (map_hit) begin
                                key_valid   <= 1'b1;
                                key_release <= is_release;
                                // Letters have bit 6 set, digits do not
                                key_ascii   <= (shift_held && map_ascii[6]) ?
                                               (map_ascii & 8'hDF) : map_ascii;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- verilog/kbd_regs.sv
`include "kbd_cfg.svh"

// Register map
//   0  control   bit0 rx_enable, bit1 decode_enable, bit2 clear overflow (W1, self-clearing)
//   1  status    bit0 FIFO not empty, bit1 overflow, bit2 shift held (RO)
//   2  frame-error count, saturating, any write clears
//   3  last make key ASCII (RO)
module kbd_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               reg_wr,
    input  kbd_pkg::reg_addr_t reg_addr,
    input  kbd_pkg::reg_data_t reg_wdata,
    input  logic               fifo_not_empty,
    input  logic               overflow,
    input  logic               shift_held,
    input  logic               frame_error,
    input  logic               key_valid,
    input  kbd_pkg::ascii_t    key_ascii,
    input  logic               key_release,
    output kbd_pkg::reg_data_t reg_rdata,
    output logic               rx_enable,
    output logic               decode_enable,
    output logic               overflow_clear
);
    import kbd_pkg::*;

    logic [`KBD_ERRCNT_W-1:0] err_cnt;
    ascii_t                   last_key;
    logic                     wr_ctrl;
    logic                     wr_err;

    assign wr_ctrl = reg_wr && (reg_addr == 2'd0);
    assign wr_err  = reg_wr && (reg_addr == 2'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_enable      <= 1'b0;
            decode_enable  <= 1'b0;
            overflow_clear <= 1'b0;
            err_cnt        <= '0;
            last_key       <= '0;
        end else begin
            overflow_clear <= wr_ctrl && reg_wdata[2];   // One-cycle pulse to the FIFO
            if (wr_ctrl) begin
                rx_enable     <= reg_wdata[0];
                decode_enable <= reg_wdata[1];
            end
            if (wr_err) begin                            // Host clear beats a new error
                err_cnt <= '0;
            end else if (frame_error && err_cnt != '1) begin
                err_cnt <= err_cnt + 1'b1;
            end
            if (key_valid && !key_release) begin
                last_key <= key_ascii;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            2'd0:    reg_rdata = {6'b0, decode_enable, rx_enable};
            2'd1:    reg_rdata = {5'b0, shift_held, overflow, fifo_not_empty};
            2'd2:    reg_rdata = reg_data_t'(err_cnt);
            2'd3:    reg_rdata = last_key;
            default: reg_rdata = '0;
        endcase
    end

endmodule

//--- verilog/ps2_kbd_top.sv
module ps2_kbd_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               ps2_clk,      // Asynchronous, from the keyboard
    input  logic               ps2_data,     // Asynchronous, from the keyboard
    input  logic               reg_wr,
    input  kbd_pkg::reg_addr_t reg_addr,
    input  kbd_pkg::reg_data_t reg_wdata,
    output kbd_pkg::reg_data_t reg_rdata,
    output logic               key_valid,
    output kbd_pkg::ascii_t    key_ascii,
    output logic               key_release
);
    import kbd_pkg::*;

    logic       code_valid;
    scan_code_t code;
    logic       frame_error;
    scan_code_t fifo_data;
    logic       fifo_not_empty;
    logic       overflow;
    logic       pop;
    logic       shift_held;
    logic       rx_enable;
    logic       decode_enable;
    logic       overflow_clear;

    ps2_frame_rx u_rx (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_enable   (rx_enable),
        .code_valid  (code_valid),
        .code        (code),
        .frame_error (frame_error)
    );

    scan_fifo u_fifo (
        .clk            (clk),
        .reset          (reset),
        .push           (code_valid),
        .push_data      (code),
        .pop            (pop),
        .overflow_clear (overflow_clear),
        .fifo_data      (fifo_data),
        .fifo_not_empty (fifo_not_empty),
        .overflow       (overflow)
    );

    scan_to_ascii u_dec (
        .clk            (clk),
        .reset          (reset),
        .decode_enable  (decode_enable),
        .fifo_not_empty (fifo_not_empty),
        .fifo_data      (fifo_data),
        .pop            (pop),
        .key_valid      (key_valid),
        .key_ascii      (key_ascii),
        .key_release    (key_release),
        .shift_held     (shift_held)
    );

    kbd_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .fifo_not_empty (fifo_not_empty),
        .overflow       (overflow),
        .shift_held     (shift_held),
        .frame_error    (frame_error),
        .key_valid      (key_valid),
        .key_ascii      (key_ascii),
        .key_release    (key_release),
        .reg_rdata      (reg_rdata),
        .rx_enable      (rx_enable),
        .decode_enable  (decode_enable),
        .overflow_clear (overflow_clear)
    );

endmodule

//--- testbench/tb_ps2_kbd.sv
module tb_ps2_kbd;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int TIMEOUT   = 2000;
    localparam int FRAME_GAP = 20;    // Idle clk cycles after each frame
    localparam int M_NORMAL  = 0;
    localparam int M_F0      = 1;
    localparam int M_E0      = 2;

    // Set 2 make codes in alphabet order, then digits 0 to 9
    localparam logic [7:0] LETTER_CODES [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
        8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    localparam logic [7:0] DIGIT_CODES [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
        8'h36, 8'h3D, 8'h3E, 8'h46};

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       reg_wr;
    logic [1:0] reg_addr;
    logic [7:0] reg_wdata;
    logic [7:0] reg_rdata;
    logic       key_valid;
    logic [7:0] key_ascii;
    logic       key_release;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          events_seen;
    logic [8:0]  exp_q [$];        // {release, ascii} in decode order
    logic [7:0]  pending_q [$];    // Model FIFO while decoding is off
    int          m_state;
    logic        m_shift_l;
    logic        m_shift_r;
    logic        m_rx_en;
    logic        m_dec_en;
    logic        m_overflow;
    logic [7:0]  m_last;
    int          m_err_cnt;

    ps2_kbd_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .key_valid   (key_valid),
        .key_ascii   (key_ascii),
        .key_release (key_release)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % n);   // Upper bits are the better ones
    endfunction

    function automatic logic [7:0] random_key();
        int idx;
        idx = rand_below(36);
        if (idx < 26) begin
            return LETTER_CODES[idx];
        end
        return DIGIT_CODES[idx - 26];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Returns {hit, lower case ascii}
    function automatic logic [8:0] key_lookup(input logic [7:0] code);
        for (int i = 0; i < 26; i++) begin
            if (code == LETTER_CODES[i]) return {1'b1, 8'h61 + 8'(i)};
        end
        for (int i = 0; i < 10; i++) begin
            if (code == DIGIT_CODES[i]) return {1'b1, 8'h30 + 8'(i)};
        end
        return 9'h000;
    endfunction

    // One byte through the reference decoder
    function automatic void model_byte(input logic [7:0] code);
        logic       rel;
        logic [8:0] hit_asc;
        logic [7:0] asc;
        hit_asc = key_lookup(code);
        if (m_state == M_E0) begin
            if (code != 8'hF0) m_state = M_NORMAL;   // E0 F0 xx skipped as a whole
        end else if (code == 8'hF0) begin
            m_state = M_F0;
        end else if (code == 8'hE0) begin
            m_state = M_E0;
        end else begin
            rel     = (m_state == M_F0);
            m_state = M_NORMAL;
            if (code == 8'h12) begin
                m_shift_l = !rel;
            end else if (code == 8'h59) begin
                m_shift_r = !rel;
            end else if (hit_asc[8]) begin
                asc = hit_asc[7:0];
                if ((m_shift_l || m_shift_r) && asc >= 8'h61) asc = asc - 8'h20;
                exp_q.push_back({rel, asc});
                if (!rel) m_last = asc;
            end
        end
    endfunction

    function automatic void model_frame(input logic [7:0] code, input logic bad);
        if (m_rx_en && bad) begin
            if (m_err_cnt < 255) m_err_cnt++;
        end else if (m_rx_en) begin
            if (m_dec_en) begin
                model_byte(code);
            end else if (pending_q.size() < 8) begin
                pending_q.push_back(code);
            end else begin
                m_overflow = 1'b1;                   // Ninth byte onward is lost
            end
        end
    endfunction

    function automatic logic [7:0] status_model();
        return {5'b0, m_shift_l | m_shift_r, m_overflow, pending_q.size() != 0};
    endfunction

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic expect_reg(input string name, input logic [1:0] addr,
                              input logic [7:0] exp);
        logic [7:0] rd;
        read_reg(addr, rd);
        check_val(name, rd, exp);
    endtask

    task automatic set_control(input logic [7:0] data);
        write_reg(2'd0, data);
        m_rx_en  = data[0];
        m_dec_en = data[1];
        if (data[2]) m_overflow = 1'b0;
        while (m_dec_en && pending_q.size() != 0) begin
            model_byte(pending_q.pop_front());
        end
    endtask

    // Start, eight data bits LSB first, parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad);
        logic [10:0] bits;
        model_frame(code, bad);   // Expected events queued before the DUT can raise key_valid
        bits = {1'b1, ~(^code) ^ bad, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= bits[i];
            repeat (10) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (10) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (FRAME_GAP) @(posedge clk);
    endtask

    task automatic send_key(input logic [7:0] code, input logic rel);
        if (rel) send_frame(8'hF0, 1'b0);
        send_frame(code, 1'b0);
    endtask

    // Wait until every expected event arrived and the FIFO is empty
    task automatic drain();
        logic [7:0] st;
        int         n;
        st = 8'h01;
        n  = 0;
        while ((exp_q.size() != 0 || st[0]) && n < TIMEOUT) begin
            read_reg(2'd1, st);
            n++;
        end
        if (n >= TIMEOUT) begin
            errors++;
            $display("Timeout: key_valid events or FIFO drain not seen in %0d cycles", TIMEOUT);
        end
        repeat (3) @(posedge clk);                   // Pop, register, decode
    endtask

    always @(negedge clk) begin : event_monitor
        logic [8:0] ev;
        if (!reset && key_valid) begin
            events_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected key event with key_ascii 0x%0h", key_ascii);
            end else begin
                ev = exp_q.pop_front();
                check_val("key_ascii", key_ascii, ev[7:0]);
                check_val("key_release", key_release, ev[8]);
            end
        end
    end

    initial begin
        #40_000_000;
        $display("Watchdog: simulation ran far longer than expected");
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        logic [7:0] code;
        logic       held;
        int         ev_start;
        rng_state   = 32'hb48a;
        errors      = 0;
        checks      = 0;
        events_seen = 0;
        m_state     = M_NORMAL;
        m_shift_l   = 1'b0;
        m_shift_r   = 1'b0;
        m_rx_en     = 1'b0;
        m_dec_en    = 1'b0;
        m_overflow  = 1'b0;
        m_last      = 8'h00;
        m_err_cnt   = 0;
        reset     <= 1'b1;
        ps2_clk   <= 1'b1;
        ps2_data  <= 1'b1;
        reg_wr    <= 1'b0;
        reg_addr  <= 2'd0;
        reg_wdata <= 8'h00;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Reset values, then a frame that must be ignored
        for (int a = 0; a < 4; a++) begin
            expect_reg($sformatf("reg%0d", a), 2'(a), 8'h00);
        end
        send_frame(random_key(), 1'b0);
        repeat (50) @(posedge clk);
        expect_reg("status", 2'd1, status_model());
        expect_reg("err_cnt", 2'd2, 8'h00);

        // Plain make/break traffic
        set_control(8'h03);
        repeat (20) begin
            code = random_key();
            send_key(code, 1'b0);
            if (rand_below(2) != 0) send_key(code, 1'b1);
            drain();
            expect_reg("last_key", 2'd3, m_last);
        end

        // Shift presses mixed with letters
        repeat (24) begin
            if (rand_below(4) == 0) begin
                code = (rand_below(2) != 0) ? 8'h12 : 8'h59;
                held = (code == 8'h12) ? m_shift_l : m_shift_r;
                send_key(code, held);
            end else begin
                code = LETTER_CODES[rand_below(26)];
                send_key(code, 1'b0);
                send_key(code, 1'b1);
            end
            drain();
            expect_reg("status", 2'd1, status_model());
            expect_reg("last_key", 2'd3, m_last);
        end
        if (m_shift_l) send_key(8'h12, 1'b1);
        if (m_shift_r) send_key(8'h59, 1'b1);
        drain();

        // Parity errors and the error counter
        repeat (1 + rand_below(4)) send_frame(random_key(), 1'b1);
        drain();
        expect_reg("err_cnt", 2'd2, m_err_cnt[7:0]);
        write_reg(2'd2, 8'hFF);
        m_err_cnt = 0;
        expect_reg("err_cnt", 2'd2, 8'h00);

        // Back-pressure and overflow
        set_control(8'h01);
        repeat (12) send_frame(random_key(), 1'b0);
        expect_reg("status", 2'd1, status_model());
        ev_start = events_seen;
        set_control(8'h03);
        drain();
        check_val("event_count", events_seen - ev_start, 8);
        expect_reg("status", 2'd1, status_model());
        set_control(8'h07);
        expect_reg("status", 2'd1, status_model());
        expect_reg("control", 2'd0, 8'h03);

        // Extended codes are skipped
        repeat (5) begin
            code = random_key();
            send_frame(8'hE0, 1'b0);
            send_frame(code, 1'b0);
            send_frame(8'hE0, 1'b0);
            send_key(code, 1'b1);
            code = random_key();
            send_key(code, 1'b0);
            send_key(code, 1'b1);
            drain();
            expect_reg("last_key", 2'd3, m_last);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/kbd_pkg.sv
verilog/ps2_frame_rx.sv
verilog/scan_fifo.sv
verilog/scan_to_ascii.sv
verilog/kbd_regs.sv
verilog/ps2_kbd_top.sv
testbench/tb_ps2_kbd.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_ps2_kbd -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ps2_kbd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "Simulation reported errors"
exit 1
